//--- backend_cfg.svh
`ifndef BACKEND_CFG_SVH
`define BACKEND_CFG_SVH

// Datapath and structure sizes.
`define XLEN          16
`define NUM_ARCH_REGS 8
`define NUM_PHY_REGS  16
`define ROB_DEPTH     8

// One shift-add step per multiplier bit.
`define MUL_STEPS     `XLEN

`endif

//--- hw/cpu_params.sv
`default_nettype none

`include "backend_cfg.svh"

package cpu_params;

    typedef logic [`XLEN-1:0]                  word_t;
    typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`NUM_PHY_REGS)-1:0]  phy_reg_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0]     rob_id_t;

endpackage

`default_nettype wire

//--- hw/uop_types.sv
`default_nettype none

`include "backend_cfg.svh"

package uop_types;
    import cpu_params::*;

    typedef enum logic [1:0] {
        OP_LI,
        OP_ADD,
        OP_MUL
    } op_e;

    typedef struct packed {
        op_e       op;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        word_t     imm;
    } uop_t;

    typedef enum logic [2:0] {
        RS_IDLE,
        RS_WAIT,
        RS_READ,
        RS_EXEC,
        RS_BCAST
    } rs_state_e;

    typedef logic [$clog2(`MUL_STEPS)-1:0] mul_cnt_t;
    localparam mul_cnt_t MUL_LAST = mul_cnt_t'(`MUL_STEPS - 1); // Final multiply step.

endpackage

`default_nettype wire

//--- hw/backend_itf.sv
`default_nettype none

interface cdb_itf
    import cpu_params::*;
();
    logic     valid;
    phy_reg_t phy;
    rob_id_t  rob_id;
    word_t    value;

    modport driver (output valid, phy, rob_id, value);
    modport listener (input valid, phy, rob_id, value);
endinterface

interface ds_rs_itf
    import cpu_params::*;
    import uop_types::*;
();
    logic     valid;
    logic     ready;
    op_e      op;
    phy_reg_t rd_phy;
    phy_reg_t ps1;
    phy_reg_t ps2;
    logic     rs1_rdy;
    logic     rs2_rdy;
    word_t    imm;
    rob_id_t  rob_id;

    modport ds (output valid, op, rd_phy, ps1, ps2, rs1_rdy, rs2_rdy, imm, rob_id,
                input ready);
    modport rs (input valid, op, rd_phy, ps1, ps2, rs1_rdy, rs2_rdy, imm, rob_id,
                output ready);
endinterface

interface id_rob_itf
    import cpu_params::*;
();
    logic      alloc;
    arch_reg_t rd_arch;
    phy_reg_t  rd_phy;
    phy_reg_t  old_phy;
    logic      alloc_ready; // ROB not full.
    rob_id_t   rob_id;      // Tail slot.

    modport id (output alloc, rd_arch, rd_phy, old_phy, input alloc_ready, rob_id);
    modport rob (input alloc, rd_arch, rd_phy, old_phy, output alloc_ready, rob_id);
endinterface

interface rs_prf_itf
    import cpu_params::*;
();
    phy_reg_t raddr1;
    phy_reg_t raddr2;
    word_t    rdata1;
    word_t    rdata2;

    modport rs (output raddr1, raddr2, input rdata1, rdata2);
    modport prf (input raddr1, raddr2, output rdata1, rdata2);
endinterface

`default_nettype wire

//--- hw/id_stage.sv
`default_nettype none

module id_stage
    import cpu_params::*;
    import uop_types::*;
(
    input  logic      uop_valid_i,
    input  uop_t      uop_i,
    output logic      uop_ready_o,

    output arch_reg_t rs1_o,
    output arch_reg_t rs2_o,
    input  phy_reg_t  ps1_i,
    input  phy_reg_t  ps2_i,
    input  logic      rs1_rdy_i,
    input  logic      rs2_rdy_i,

    output logic      rename_o,
    output arch_reg_t rd_o,
    input  phy_reg_t  free_phy_i,
    input  logic      free_empty_i,
    input  phy_reg_t  old_phy_i,

    id_rob_itf.id     to_rob,
    ds_rs_itf.ds      to_rs
);

    logic can_issue;
    logic accept;

    // Need a free register and a ROB slot.
    assign can_issue   = !free_empty_i && to_rob.alloc_ready;
    assign uop_ready_o = can_issue && to_rs.ready;
    assign accept      = uop_valid_i && uop_ready_o;

    assign rs1_o    = uop_i.rs1;
    assign rs2_o    = uop_i.rs2;
    assign rd_o     = uop_i.rd;
    assign rename_o = accept;

    assign to_rob.alloc   = accept;
    assign to_rob.rd_arch = uop_i.rd;
    assign to_rob.rd_phy  = free_phy_i;
    assign to_rob.old_phy = old_phy_i;

    // Station sees the renamed uop; it transfers on its own ready.
    assign to_rs.valid   = uop_valid_i && can_issue;
    assign to_rs.op      = uop_i.op;
    assign to_rs.rd_phy  = free_phy_i;
    assign to_rs.ps1     = ps1_i;
    assign to_rs.ps2     = ps2_i;
    assign to_rs.rs1_rdy = rs1_rdy_i;
    assign to_rs.rs2_rdy = rs2_rdy_i;
    assign to_rs.imm     = uop_i.imm;
    assign to_rs.rob_id  = to_rob.rob_id;

endmodule

`default_nettype wire

//--- hw/rename_map.sv
`default_nettype none

module rename_map
    import cpu_params::*;
(
    input  logic      clk,
    input  logic      rst_n_i,

    input  arch_reg_t rs1_i,
    input  arch_reg_t rs2_i,
    output phy_reg_t  ps1_o,
    output phy_reg_t  ps2_o,
    output logic      rs1_rdy_o,
    output logic      rs2_rdy_o,

    input  logic      rename_i,
    input  arch_reg_t rd_i,
    output phy_reg_t  free_phy_o,
    output logic      free_empty_o,
    output phy_reg_t  old_phy_o,

    input  logic      free_valid_i,
    input  phy_reg_t  free_phy_i,

    cdb_itf.listener  cdb
);

    localparam int NARCH = 2 ** $bits(arch_reg_t);
    localparam int NPHY  = 2 ** $bits(phy_reg_t);
    localparam int CNT_W = $bits(phy_reg_t) + 1;

    phy_reg_t         map_q [NARCH];
    logic [NPHY-1:0]  prdy_q;        // Per physical register.
    phy_reg_t         fl_q [NPHY];
    phy_reg_t         fl_head_q;
    phy_reg_t         fl_tail_q;
    logic [CNT_W-1:0] fl_count_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NARCH; i++) begin
                map_q[i] <= phy_reg_t'(i);
            end
            // Registers above the identity mapping start free.
            for (int i = 0; i < NPHY; i++) begin
                fl_q[i] <= phy_reg_t'(i + NARCH);
            end
            prdy_q     <= '1;
            fl_head_q  <= '0;
            fl_tail_q  <= phy_reg_t'(NPHY - NARCH);
            fl_count_q <= CNT_W'(NPHY - NARCH);
        end else begin
            if (rename_i) begin
                map_q[rd_i]            <= fl_q[fl_head_q];
                prdy_q[fl_q[fl_head_q]] <= 1'b0;
                fl_head_q              <= fl_head_q + 1'b1;
            end
            if (cdb.valid) begin
                prdy_q[cdb.phy] <= 1'b1;
            end
            if (free_valid_i) begin
                fl_q[fl_tail_q] <= free_phy_i;
                fl_tail_q       <= fl_tail_q + 1'b1;
            end
            fl_count_q <= fl_count_q + CNT_W'(free_valid_i) - CNT_W'(rename_i);
        end
    end

    assign ps1_o = map_q[rs1_i];
    assign ps2_o = map_q[rs2_i];

    // Same-cycle CDB bypass.
    assign rs1_rdy_o = prdy_q[ps1_o] || (cdb.valid && cdb.phy == ps1_o);
    assign rs2_rdy_o = prdy_q[ps2_o] || (cdb.valid && cdb.phy == ps2_o);

    assign free_phy_o   = fl_q[fl_head_q];
    assign free_empty_o = (fl_count_q == '0);
    assign old_phy_o    = map_q[rd_i];

endmodule

`default_nettype wire

//--- hw/rob.sv
`default_nettype none

`include "backend_cfg.svh"

module rob
    import cpu_params::*;
(
    input  logic      clk,
    input  logic      rst_n_i,

    id_rob_itf.rob    from_id,
    cdb_itf.listener  cdb,

    output logic      free_valid_o,
    output phy_reg_t  free_phy_o,

    output logic      commit_valid_o,
    output arch_reg_t commit_rd_o,
    output word_t     commit_value_o
);

    localparam int DEPTH = `ROB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    arch_reg_t        rd_arch_q [DEPTH];
    phy_reg_t         rd_phy_q [DEPTH];
    phy_reg_t         old_phy_q [DEPTH];
    word_t            value_q [DEPTH];
    logic [DEPTH-1:0] done_q;
    rob_id_t          head_q;
    rob_id_t          tail_q;
    logic [CNT_W-1:0] count_q;
    logic             retire;
    logic             cdb_hit;

    assign retire  = (count_q != '0) && done_q[head_q];
    assign cdb_hit = cdb.valid && (cdb.phy == rd_phy_q[cdb.rob_id]); // Tag must match entry.

    assign from_id.alloc_ready = (count_q != CNT_W'(DEPTH));
    assign from_id.rob_id      = tail_q;

    assign free_valid_o = retire;
    assign free_phy_o   = old_phy_q[head_q];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            head_q         <= '0;
            tail_q         <= '0;
            count_q        <= '0;
            done_q         <= '0;
            commit_valid_o <= 1'b0;
        end else begin
            if (from_id.alloc) begin
                tail_q         <= tail_q + 1'b1;
                done_q[tail_q] <= 1'b0;
            end
            if (cdb_hit) begin
                done_q[cdb.rob_id] <= 1'b1;
            end
            if (retire) begin
                head_q <= head_q + 1'b1;
            end
            count_q        <= count_q + CNT_W'(from_id.alloc) - CNT_W'(retire);
            commit_valid_o <= retire;
        end
    end

    // Entry payload.
    always_ff @(posedge clk) begin
        if (from_id.alloc) begin
            rd_arch_q[tail_q] <= from_id.rd_arch;
            rd_phy_q[tail_q]  <= from_id.rd_phy;
            old_phy_q[tail_q] <= from_id.old_phy;
        end
        if (cdb_hit) begin
            value_q[cdb.rob_id] <= cdb.value;
        end
        if (retire) begin
            commit_rd_o    <= rd_arch_q[head_q];
            commit_value_o <= value_q[head_q];
        end
    end

endmodule

`default_nettype wire

//--- hw/intm_rs.sv
`default_nettype none

module intm_rs
    import cpu_params::*;
    import uop_types::*;
(
    input  logic   clk,
    input  logic   rst_n_i,

    ds_rs_itf.rs   from_ds,
    rs_prf_itf.rs  to_prf,
    cdb_itf.driver cdb
);

    rs_state_e state_q, state_d;
    logic      ready_q;
    logic      rdy1_q, rdy2_q;
    mul_cnt_t  step_q;
    op_e       op_q;
    phy_reg_t  rd_phy_q;
    phy_reg_t  ps1_q, ps2_q;
    word_t     imm_q;
    rob_id_t   rob_id_q;
    word_t     src1_q, src2_q;  // Multiplicand and multiplier during MUL.
    word_t     result_q;
    logic      capture;
    logic      wake1, wake2;

    assign capture = from_ds.valid && from_ds.ready;
    assign wake1   = cdb.valid && (cdb.phy == ps1_q);
    assign wake2   = cdb.valid && (cdb.phy == ps2_q);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            RS_IDLE: begin
                if (capture) begin
                    state_d = (from_ds.rs1_rdy && from_ds.rs2_rdy) ? RS_READ : RS_WAIT;
                end
            end
            RS_WAIT: begin
                if ((rdy1_q || wake1) && (rdy2_q || wake2)) begin
                    state_d = RS_READ;
                end
            end
            RS_READ:  state_d = RS_EXEC;
            RS_EXEC: begin
                if (op_q != OP_MUL || step_q == MUL_LAST) begin
                    state_d = RS_BCAST;
                end
            end
            RS_BCAST: state_d = RS_IDLE;
            default:  state_d = RS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= RS_IDLE;
            ready_q <= 1'b0;
            rdy1_q  <= 1'b0;
            rdy2_q  <= 1'b0;
            step_q  <= '0;
        end else begin
            state_q <= state_d;
            ready_q <= (state_d == RS_IDLE);
            if (capture) begin
                rdy1_q <= from_ds.rs1_rdy;
                rdy2_q <= from_ds.rs2_rdy;
            end else begin
                rdy1_q <= rdy1_q || wake1;
                rdy2_q <= rdy2_q || wake2;
            end
            if (state_q == RS_READ) begin
                step_q <= '0;
            end else if (state_q == RS_EXEC) begin
                step_q <= step_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            op_q     <= from_ds.op;
            rd_phy_q <= from_ds.rd_phy;
            ps1_q    <= from_ds.ps1;
            ps2_q    <= from_ds.ps2;
            imm_q    <= from_ds.imm;
            rob_id_q <= from_ds.rob_id;
        end
        if (state_q == RS_READ) begin
            src1_q   <= to_prf.rdata1;
            src2_q   <= to_prf.rdata2;
            result_q <= '0;
        end else if (state_q == RS_EXEC) begin
            unique case (op_q)
                OP_LI:  result_q <= imm_q;
                OP_ADD: result_q <= src1_q + src2_q;
                default: begin
                    // Shift-add step keeping the low XLEN bits.
                    if (src2_q[0]) begin
                        result_q <= result_q + src1_q;
                    end
                    src1_q <= src1_q << 1;
                    src2_q <= src2_q >> 1;
                end
            endcase
        end
    end

    assign from_ds.ready = ready_q;

    assign to_prf.raddr1 = ps1_q;
    assign to_prf.raddr2 = ps2_q;

    assign cdb.valid  = (state_q == RS_BCAST);
    assign cdb.phy    = rd_phy_q;
    assign cdb.rob_id = rob_id_q;
    assign cdb.value  = result_q;

endmodule

`default_nettype wire

//--- hw/prf.sv
`default_nettype none

module prf
    import cpu_params::*;
(
    input  logic     clk,
    input  logic     rst_n_i,

    rs_prf_itf.prf   from_rs,
    cdb_itf.listener cdb
);

    localparam int NPHY = 2 ** $bits(phy_reg_t);

    word_t regs_q [NPHY];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NPHY; i++) begin
                regs_q[i] <= '0;
            end
        end else if (cdb.valid) begin
            regs_q[cdb.phy] <= cdb.value; // Single write port.
        end
    end

    assign from_rs.rdata1 = regs_q[from_rs.raddr1];
    assign from_rs.rdata2 = regs_q[from_rs.raddr2];

endmodule

`default_nettype wire

//--- hw/backend_top.sv
`default_nettype none

module backend_top
    import cpu_params::*;
    import uop_types::*;
(
    input  logic      clk,
    input  logic      rst_n_i,

    input  logic      uop_valid_i,
    input  uop_t      uop_i,
    output logic      uop_ready_o,

    output logic      commit_valid_o,
    output arch_reg_t commit_rd_o,
    output word_t     commit_value_o
);

    cdb_itf    cdb_itf_i();
    ds_rs_itf  ds_rs_itf_i();
    id_rob_itf id_rob_itf_i();
    rs_prf_itf rs_prf_itf_i();

    arch_reg_t rs1, rs2, rd;
    phy_reg_t  ps1, ps2;
    logic      rs1_rdy, rs2_rdy;
    logic      rename;
    phy_reg_t  free_phy;
    logic      free_empty;
    phy_reg_t  old_phy;
    logic      free_valid;  // Commit returns a register.
    phy_reg_t  ret_phy;

    id_stage id_stage_i (
        .uop_valid_i  (uop_valid_i),
        .uop_i        (uop_i),
        .uop_ready_o  (uop_ready_o),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .ps1_i        (ps1),
        .ps2_i        (ps2),
        .rs1_rdy_i    (rs1_rdy),
        .rs2_rdy_i    (rs2_rdy),
        .rename_o     (rename),
        .rd_o         (rd),
        .free_phy_i   (free_phy),
        .free_empty_i (free_empty),
        .old_phy_i    (old_phy),
        .to_rob       (id_rob_itf_i),
        .to_rs        (ds_rs_itf_i)
    );

    rename_map rename_map_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .ps1_o        (ps1),
        .ps2_o        (ps2),
        .rs1_rdy_o    (rs1_rdy),
        .rs2_rdy_o    (rs2_rdy),
        .rename_i     (rename),
        .rd_i         (rd),
        .free_phy_o   (free_phy),
        .free_empty_o (free_empty),
        .old_phy_o    (old_phy),
        .free_valid_i (free_valid),
        .free_phy_i   (ret_phy),
        .cdb          (cdb_itf_i)
    );

    rob rob_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .from_id        (id_rob_itf_i),
        .cdb            (cdb_itf_i),
        .free_valid_o   (free_valid),
        .free_phy_o     (ret_phy),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_value_o (commit_value_o)
    );

    intm_rs intm_rs_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .from_ds (ds_rs_itf_i),
        .to_prf  (rs_prf_itf_i),
        .cdb     (cdb_itf_i)
    );

    prf prf_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .from_rs (rs_prf_itf_i),
        .cdb     (cdb_itf_i)
    );

endmodule

`default_nettype wire

//--- tb/backend_props.sv
`default_nettype none

`include "backend_cfg.svh"

module backend_props (
    input logic                         clk,
    input logic                         rst_n_i,
    input logic [$clog2(`ROB_DEPTH):0]  count_i,
    input logic                         commit_valid_i
);

    localparam int DEPTH = `ROB_DEPTH;

    count_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        int'(count_i) <= DEPTH)
        else $error("ROB count above its depth");

    // A commit needs an occupied entry in the cycle before.
    commit_not_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_i |-> $past(count_i) != '0)
        else $error("ROB committed while empty");

    reset_quiet: assert property (@(posedge clk)
        !rst_n_i |=> !commit_valid_i)
        else $error("ROB commit during reset");

endmodule

`default_nettype wire

//--- tb/backend_tb.sv
`default_nettype none

`include "backend_cfg.svh"

module backend_tb
    import cpu_params::*;
    import uop_types::*;
();

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 4;
    localparam int NUM_UOPS      = 300;
    localparam int WATCHDOG_TIME = NUM_UOPS * (`MUL_STEPS + 8) * CLK_PERIOD
                                   + RESET_CYCLES * CLK_PERIOD;

    logic      clk;
    logic      rst_n_i;
    logic      uop_valid_i;
    uop_t      uop_i;
    logic      uop_ready_o;
    logic      commit_valid_o;
    arch_reg_t commit_rd_o;
    word_t     commit_value_o;

    logic [31:0] rng_state;
    word_t       arch_q [`NUM_ARCH_REGS]; // Architectural model state.
    uop_t        pending_q [$];
    arch_reg_t   last_rd;
    logic        ready_prev;
    int          sent;
    int          committed;

    backend_top DUT (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .uop_valid_i    (uop_valid_i),
        .uop_i          (uop_i),
        .uop_ready_o    (uop_ready_o),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_value_o (commit_value_o)
    );

    bind rob backend_props rob_props (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .count_i        (count_q),
        .commit_valid_i (commit_valid_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic uop_t random_uop();
        logic [31:0] r;
        uop_t        u;
        r     = next_rand();
        u.op  = (r[1:0] == 2'd0) ? OP_MUL : (r[2] ? OP_ADD : OP_LI); // MUL about 1 in 4.
        u.rd  = r[10:8];
        u.rs1 = (r[20:19] == 2'd0) ? last_rd : r[13:11];
        u.rs2 = r[16:14];
        u.imm = word_t'(next_rand());
        return u;
    endfunction

    // Sources are read before rd is written.
    function automatic word_t model_result(uop_t u);
        logic [31:0] prod;
        case (u.op)
            OP_LI:  return u.imm;
            OP_ADD: return arch_q[u.rs1] + arch_q[u.rs2];
            default: begin
                prod = 32'(arch_q[u.rs1]) * 32'(arch_q[u.rs2]);
                return prod[15:0];
            end
        endcase
    endfunction

    function automatic string op_name(op_e op);
        case (op)
            OP_LI:   return "li_commit";
            OP_ADD:  return "add_commit";
            default: return "mul_commit";
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %0h actual %0h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_commit();
        uop_t  u;
        word_t expected;
        if (pending_q.size() == 0) begin
            $display("Commit seen with no accepted uop left to retire");
            $display("Simulation failed");
            $fatal(1);
        end else begin
            u        = pending_q.pop_front();
            expected = model_result(u);
            arch_q[u.rd] = expected;
            compare_value("commit_order_rd", 32'(u.rd), 32'(commit_rd_o));
            compare_value(op_name(u.op), 32'(expected), 32'(commit_value_o));
            if (committed == 0) begin
                compare_value("reset_first_add", 32'(0), 32'(commit_value_o));
            end
            committed++;
        end
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired: commits stopped at %0d of %0d", committed, NUM_UOPS);
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        uop_valid_i = 1'b0;
        uop_i       = '0;
        rng_state   = 32'd49288;
        last_rd     = '0;
        ready_prev  = 1'b0;
        sent        = 0;
        committed   = 0;
        for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
            arch_q[i] = '0;
        end

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare_value("reset_uop_ready", 32'(0), 32'(uop_ready_o));
            compare_value("reset_commit_valid", 32'(0), 32'(commit_valid_o));
        end
        rst_n_i = 1'b1;

        while (committed < NUM_UOPS) begin
            @(negedge clk);
            if (commit_valid_o) begin
                check_commit();
            end
            if (uop_valid_i && ready_prev) begin
                pending_q.push_back(uop_i);
                sent++;
                if (uop_i.op == OP_MUL) begin
                    compare_value("mul_backpressure", 32'(0), 32'(uop_ready_o));
                end
                uop_valid_i = 1'b0;
            end
            if (!uop_valid_i && sent < NUM_UOPS) begin
                if (sent == 0) begin
                    uop_i       = '0; // Adds two untouched registers.
                    uop_i.op    = OP_ADD;
                    uop_i.rd    = 3'd1;
                    uop_i.rs1   = 3'd2;
                    uop_i.rs2   = 3'd3;
                    uop_valid_i = 1'b1;
                end else if (next_rand() % 4 != 0) begin
                    uop_i       = random_uop();
                    uop_valid_i = 1'b1;
                end
                if (uop_valid_i) begin
                    last_rd = uop_i.rd;
                end
            end
            ready_prev = uop_ready_o;
        end

        // No stray commits once everything retired.
        repeat (2 * `MUL_STEPS) begin
            @(negedge clk);
            compare_value("extra_commit", 32'(0), 32'(commit_valid_o));
        end
        // Drained backend takes new uops again.
        compare_value("idle_ready", 32'(1), 32'(uop_ready_o));
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- backend.f
+incdir+.
hw/cpu_params.sv
hw/uop_types.sv
hw/backend_itf.sv
hw/id_stage.sv
hw/rename_map.sv
hw/rob.sv
hw/intm_rs.sv
hw/prf.sv
hw/backend_top.sv
tb/backend_props.sv
tb/backend_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f backend.f --top-module backend_tb

# A failing run is judged from the log below.
./obj_dir/Vbackend_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation completed successfully" sim.log
